// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vga_tb
SEED_ARGS ?= +verilator+seed+1

VFLAGS   = --assert --timing --timescale 1ns/10ps -f src.f --top-module $(TOP)
PASS_MSG = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

# exit status comes from the search for the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP) $(SEED_ARGS) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/vga_assert.sv ====
`timescale 1ns/10ps

module vga_assert (
   input logic                   i_clock,
   input logic                   i_reset,
   input vga_cmd_pkg::vga_inst_t i_inst,
   input logic                   i_inst_en,
   input logic                   o_error,
   input logic                   o_vga_hsync,
   input logic                   o_vga_vsync,
   input logic                   o_vga_r,
   input logic                   o_vga_g,
   input logic                   o_vga_b
);

   import vga_cmd_pkg::*;
   import vga_timing_pkg::*;

   int   fail_count = 0;
   logic hs_q;
   logic vs_q;
   logic hs_rise;
   logic hs_fall;
   logic vs_rise;
   logic vs_fall;
   logic h_seen;
   logic v_seen;
   int   h_run;   // cycles high so far
   int   v_run;
   int   h_per;   // cycles since the last rise
   int   v_per;
   logic bad_op;

   assign hs_rise = o_vga_hsync & ~hs_q;
   assign hs_fall = ~o_vga_hsync & hs_q;
   assign vs_rise = o_vga_vsync & ~vs_q;
   assign vs_fall = ~o_vga_vsync & vs_q;
   assign bad_op  = i_inst_en && !(i_inst.op inside {op_nop, op_ldr, op_ldc, op_ldd, op_ldi});

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         hs_q   <= 1'b0;
         vs_q   <= 1'b0;
         h_seen <= 1'b0;
         v_seen <= 1'b0;
         h_run  <= 0;
         v_run  <= 0;
         h_per  <= 0;
         v_per  <= 0;
      end else begin
         hs_q   <= o_vga_hsync;
         vs_q   <= o_vga_vsync;
         h_seen <= h_seen | hs_rise;
         v_seen <= v_seen | vs_rise;
         h_run  <= o_vga_hsync ? h_run + 1 : 0;
         v_run  <= o_vga_vsync ? v_run + 1 : 0;
         h_per  <= hs_rise ? 1 : h_per + 1;
         v_per  <= vs_rise ? 1 : v_per + 1;
      end
   end

   assert property (@(posedge i_clock) disable iff (i_reset)
      hs_fall |-> h_run == int'(h_sync))
   else begin
      fail_count++;
      $error("Error at %0t: hsync pulse lasted %0d cycles", $time, h_run);
   end

   assert property (@(posedge i_clock) disable iff (i_reset)
      hs_rise && h_seen |-> h_per == int'(h_total))
   else begin
      fail_count++;
      $error("Error at %0t: hsync period was %0d cycles", $time, h_per);
   end

   // vertical checks counted in clock cycles, whole lines each
   assert property (@(posedge i_clock) disable iff (i_reset)
      vs_fall |-> v_run == int'(v_sync) * int'(h_total))
   else begin
      fail_count++;
      $error("Error at %0t: vsync pulse lasted %0d cycles", $time, v_run);
   end

   assert property (@(posedge i_clock) disable iff (i_reset)
      vs_rise && v_seen |-> v_per == int'(v_total) * int'(h_total))
   else begin
      fail_count++;
      $error("Error at %0t: vsync period was %0d cycles", $time, v_per);
   end

   assert property (@(posedge i_clock)
      i_reset |=> !(o_vga_hsync || o_vga_vsync || o_vga_r || o_vga_g || o_vga_b || o_error))
   else begin
      fail_count++;
      $error("Error at %0t: output not low after a reset cycle", $time);
   end

   // raised by a bad opcode, then held until reset
   assert property (@(posedge i_clock) disable iff (i_reset)
      (bad_op || o_error) |=> o_error)
   else begin
      fail_count++;
      $error("Error at %0t: o_error low after an unknown opcode", $time);
   end

endmodule

bind vga_top vga_assert u_vga_assert (.*);

// ==== dv/vga_tb.sv ====
`timescale 1ns/10ps

module vga_tb;

   import vga_cmd_pkg::*;
   import vga_timing_pkg::*;

   logic      clock;
   logic      reset;
   vga_inst_t inst;
   logic      inst_en;
   logic      error;
   logic      hsync;
   logic      vsync;
   logic      vga_r;
   logic      vga_g;
   logic      vga_b;

   logic [fb_color_width-1:0] model_rgb [fb_depth];
   logic                      model_known [fb_depth];

   // positions written before the error
   int                        done_row [$];
   int                        done_col [$];

   // beam position seen from the sync edges
   logic                      hs_q;
   logic                      vs_q;
   int                        h_since;
   int                        line_idx;
   int                        px_x;
   int                        px_y;
   logic                      frame_valid = 1'b0;
   logic                      exp_visible;
   logic                      exp_known;
   logic [fb_color_width-1:0] exp_rgb;
   logic [fb_addr_width-1:0]  exp_addr;

   vga_top DUT (
      .i_clock     (clock),
      .i_reset     (reset),
      .i_inst      (inst),
      .i_inst_en   (inst_en),
      .o_error     (error),
      .o_vga_hsync (hsync),
      .o_vga_vsync (vsync),
      .o_vga_r     (vga_r),
      .o_vga_g     (vga_g),
      .o_vga_b     (vga_b)
   );

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   task automatic stop_on_failure(input string line);
      $display("%s", line);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   always @(negedge clock) begin
      if (reset) begin
         hs_q        = 1'b0;
         vs_q        = 1'b0;
         h_since     = 0;
         line_idx    = 0;
         frame_valid = 1'b0;
      end else begin
         if (hs_q && !hsync) begin
            h_since  = 0;
            line_idx = line_idx + 1;
         end else begin
            h_since = h_since + 1;
         end
         if (vs_q && !vsync) begin
            line_idx    = 0;
            frame_valid = 1'b1;
         end
         hs_q = hsync;
         vs_q = vsync;
      end
      px_x        = h_since - int'(h_back);
      px_y        = line_idx - int'(v_back);
      exp_visible = (px_x >= 0) && (px_x < int'(h_visible))
                    && (px_y >= 0) && (px_y < int'(v_visible));
      exp_addr    = exp_visible ? fb_addr_width'((px_y >> px_scale_log2) * fb_width
                                                 + (px_x >> px_scale_log2)) : '0;
      exp_known   = exp_visible && model_known[exp_addr];
      exp_rgb     = exp_visible ? model_rgb[exp_addr] : '0;   // black in blanking
   end

   assert property (@(posedge clock) disable iff (!frame_valid)
      (exp_known || !exp_visible) |-> ({vga_r, vga_g, vga_b} == exp_rgb))
   else stop_on_failure($sformatf("Error at %0t: pixel (%0d,%0d) shows %b, expected %b",
                        $time, px_x, px_y, $sampled({vga_r, vga_g, vga_b}), exp_rgb));

   always @(DUT.u_vga_assert.fail_count) begin
      if (DUT.u_vga_assert.fail_count != 0) begin
         stop_on_failure($sformatf("Error at %0t: a bound assertion failed", $time));
      end
   end

   task automatic send(input logic [3:0] op, input logic [7:0] imm);
      inst.op      = op;
      inst.imm.pos = imm;
      inst_en      = 1'b1;
      @(negedge clock);
      inst_en      = 1'b0;
   endtask

   // only pointers inside the buffer reach it
   task automatic model_store(input int row, input int col, input logic [2:0] rgb);
      logic [fb_addr_width-1:0] addr;
      if (row < fb_height && col < fb_width) begin
         addr              = fb_addr_width'(row * fb_width + col);
         model_rgb[addr]   = rgb;
         model_known[addr] = 1'b1;
      end
   endtask

   task automatic write_pixel(input int row, input int col, input logic [2:0] rgb,
                              input bit accepted);
      send(op_ldr, 8'(row));
      send(op_ldc, 8'(col));
      send(op_ldd, {5'($urandom), rgb});
      if (accepted) begin
         model_store(row, col, rgb);
         done_row.push_back(row);
         done_col.push_back(col);
      end
   endtask

   task automatic ldi_run(input int row, input int col, input int len);
      logic [2:0] rgb;
      send(op_ldr, 8'(row));
      send(op_ldc, 8'(col));
      for (int i = 0; i < len; i++) begin
         if ($urandom % 4 == 0) begin
            inst.op      = 4'hf;   // junk on the bus with enable low
            inst.imm.pos = 8'($urandom);
            @(negedge clock);
         end
         if ($urandom % 4 == 0) begin
            send(op_nop, 8'($urandom));
         end
         rgb = 3'($urandom);
         send(op_ldi, {5'($urandom), rgb});
         model_store(row, col, rgb);
         col = (col + 1) % 256;
      end
   endtask

   task automatic wait_vblank();
      @(posedge vsync);
      @(negedge clock);
   endtask

   initial begin
      logic [3:0] bad_op;
      int         pick;
      logic [2:0] old_rgb;
      reset   = 1'b1;
      inst_en = 1'b0;
      inst    = '0;
      void'($urandom(32'h08559c8d));
      foreach (model_rgb[a]) begin
         model_rgb[a]   = '0;
         model_known[a] = 1'b0;
      end
      repeat (4) @(negedge clock);
      reset = 1'b0;

      // writes land in vertical blanking and show in the next frame
      wait_vblank();
      repeat (64) begin
         write_pixel($urandom % fb_height, $urandom % fb_width, 3'($urandom), 1'b1);
      end
      ldi_run($urandom % fb_height, 180, 40);   // runs past the last column

      wait_vblank();
      bad_op = 4'(5 + $urandom % 11);
      send(bad_op, 8'($urandom));
      // new colors on pixels the frame already shows
      repeat (16) begin
         pick    = $urandom % done_row.size();
         old_rgb = model_rgb[fb_addr_width'(done_row[pick] * fb_width + done_col[pick])];
         write_pixel(done_row[pick], done_col[pick], ~old_rgb, 1'b0);
      end

      wait_vblank();
      if (DUT.u_vga_assert.fail_count == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_on_failure($sformatf("Error at %0t: bound assertions reported failures", $time));
      end
   end

   // three frames of stimulus plus one of margin
   initial begin
      repeat (4 * int'(h_total) * int'(v_total)) @(posedge clock);
      stop_on_failure("Timeout: the run did not finish within four frames");
   end

endmodule

// ==== logic/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer (
   input  logic                                   i_clock,
   input  logic                                   i_wr_en,
   input  logic [vga_cmd_pkg::fb_addr_width-1:0]  i_wr_addr,
   input  logic [vga_cmd_pkg::fb_color_width-1:0] i_wr_color,
   input  logic [vga_cmd_pkg::fb_addr_width-1:0]  i_rd_addr,
   output logic [vga_cmd_pkg::fb_color_width-1:0] o_rd_color
);

   import vga_cmd_pkg::*;

   // one 3-bit word per buffer pixel
   logic [fb_color_width-1:0] mem [fb_depth];

   always_ff @(posedge i_clock) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_color;
      end
   end

   // registered read, old data on a same-address write
   always_ff @(posedge i_clock) begin
      o_rd_color <= mem[i_rd_addr];
   end

endmodule

// ==== logic/vga_cmd_decoder.sv ====
`timescale 1ns/10ps

module vga_cmd_decoder (
   input  logic                                   i_clock,
   input  logic                                   i_reset,
   input  vga_cmd_pkg::vga_inst_t                 i_inst,
   input  logic                                   i_inst_en,
   output logic                                   o_wr_en,
   output logic [vga_cmd_pkg::fb_addr_width-1:0]  o_wr_addr,
   output logic [vga_cmd_pkg::fb_color_width-1:0] o_wr_color,
   output logic                                   o_error
);

   import vga_cmd_pkg::*;

   logic [st_width-1:0]      state;
   logic [7:0]               row;
   logic [7:0]               col;
   logic [fb_addr_width-1:0] cur_addr;
   logic                     in_range;

   // pointer position in the buffer, before any LDI increment
   assign cur_addr = fb_addr_width'(int'(row) * fb_width + int'(col));
   assign in_range = (int'(row) < fb_height) && (int'(col) < fb_width);

   assign o_error = (state == st_error);

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         state   <= st_reset;
         row     <= '0;
         col     <= '0;
         o_wr_en <= 1'b0;
      end else begin
         o_wr_en <= 1'b0;   // single-cycle write strobe
         case (state)
            st_reset, st_ready: begin
               state <= st_ready;
               if (i_inst_en) begin
                  case (i_inst.op)
                     op_nop: ;
                     op_ldr: row <= i_inst.imm.pos;
                     op_ldc: col <= i_inst.imm.pos;
                     op_ldd: o_wr_en <= in_range;
                     op_ldi: begin
                        o_wr_en <= in_range;
                        col     <= col + 8'd1;   // wraps at 256
                     end
                     default: begin
                        // unknown opcode, sticky until reset
                        state <= st_error;
                        row   <= '0;
                        col   <= '0;
                     end
                  endcase
               end
            end
            default: begin
               state <= st_error;
               row   <= '0;
               col   <= '0;
            end
         endcase
      end
   end

   // write payload, qualified by o_wr_en
   always_ff @(posedge i_clock) begin
      o_wr_addr  <= cur_addr;
      o_wr_color <= i_inst.imm.pix.rgb;
   end

endmodule

// ==== logic/vga_cmd_pkg.sv ====
package vga_cmd_pkg;

   // instruction opcodes
   localparam logic [3:0] op_nop = 4'h0;
   localparam logic [3:0] op_ldr = 4'h1;   // load row pointer
   localparam logic [3:0] op_ldc = 4'h2;   // load column pointer
   localparam logic [3:0] op_ldd = 4'h3;   // write color
   localparam logic [3:0] op_ldi = 4'h4;   // write color, then column + 1

   // decoder states
   localparam int st_width = 2;
   localparam logic [st_width-1:0] st_reset = 2'd0;
   localparam logic [st_width-1:0] st_ready = 2'd1;
   localparam logic [st_width-1:0] st_error = 2'd2;

   // frame buffer geometry
   localparam int fb_width       = 200;
   localparam int fb_height      = 150;
   localparam int fb_addr_width  = 15;
   localparam int fb_depth       = 30000;
   localparam int fb_color_width = 3;

   // immediate byte, read as a pointer or as a color
   typedef union packed {
      logic [7:0] pos;
      struct packed {
         logic [4:0]                pad;
         logic [fb_color_width-1:0] rgb;   // r, g, b from msb
      } pix;
   } vga_imm_u;

   typedef struct packed {
      logic [3:0] op;
      vga_imm_u   imm;
   } vga_inst_t;

endpackage

// ==== logic/vga_timing_gen.sv ====
`timescale 1ns/10ps

module vga_timing_gen (
   input  logic                                   i_clock,
   input  logic                                   i_reset,
   output logic [vga_cmd_pkg::fb_addr_width-1:0]  o_rd_addr,
   input  logic [vga_cmd_pkg::fb_color_width-1:0] i_rd_color,
   output logic                                   o_vga_hsync,
   output logic                                   o_vga_vsync,
   output logic                                   o_vga_r,
   output logic                                   o_vga_g,
   output logic                                   o_vga_b
);

   import vga_cmd_pkg::*;
   import vga_timing_pkg::*;

   logic [cnt_width-1:0] h_cnt;
   logic [cnt_width-1:0] v_cnt;
   logic                 hs;
   logic                 vs;
   logic                 visible;
   logic                 visible_d;   // aligned with i_rd_color

   // scan counters, start on the first visible pixel
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == h_total - 11'd1) begin
         h_cnt <= '0;
         if (v_cnt == v_total - 11'd1) begin
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + 11'd1;
         end
      end else begin
         h_cnt <= h_cnt + 11'd1;
      end
   end

   assign hs      = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
   assign vs      = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
   assign visible = (h_cnt < h_visible) && (v_cnt < v_visible);

   // buffer pixel under the beam, parked at 0 in blanking
   assign o_rd_addr = visible
      ? fb_addr_width'(int'(v_cnt >> px_scale_log2) * fb_width
                       + int'(h_cnt >> px_scale_log2))
      : '0;

   // one cycle delay to match the RAM read
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_vga_hsync <= 1'b0;
         o_vga_vsync <= 1'b0;
         visible_d   <= 1'b0;
      end else begin
         o_vga_hsync <= hs;
         o_vga_vsync <= vs;
         visible_d   <= visible;
      end
   end

   // blanking outside the visible area
   assign o_vga_r = visible_d & i_rd_color[2];
   assign o_vga_g = visible_d & i_rd_color[1];
   assign o_vga_b = visible_d & i_rd_color[0];

endmodule

// ==== logic/vga_timing_pkg.sv ====
package vga_timing_pkg;

   localparam int cnt_width = 11;

   // 800x600 at 72 Hz, one pixel per clock
   localparam logic [cnt_width-1:0] h_visible = 11'd800;
   localparam logic [cnt_width-1:0] h_front   = 11'd56;
   localparam logic [cnt_width-1:0] h_sync    = 11'd120;
   localparam logic [cnt_width-1:0] h_back    = 11'd64;
   localparam logic [cnt_width-1:0] h_total   = 11'd1040;

   localparam logic [cnt_width-1:0] v_visible = 11'd600;
   localparam logic [cnt_width-1:0] v_front   = 11'd37;
   localparam logic [cnt_width-1:0] v_sync    = 11'd6;
   localparam logic [cnt_width-1:0] v_back    = 11'd23;
   localparam logic [cnt_width-1:0] v_total   = 11'd666;

   // sync windows, counted from the first visible pixel
   localparam logic [cnt_width-1:0] h_sync_start = h_visible + h_front;
   localparam logic [cnt_width-1:0] h_sync_end   = h_sync_start + h_sync;
   localparam logic [cnt_width-1:0] v_sync_start = v_visible + v_front;
   localparam logic [cnt_width-1:0] v_sync_end   = v_sync_start + v_sync;

   // 4x4 screen pixels per buffer pixel
   localparam int px_scale_log2 = 2;

endpackage

// ==== logic/vga_top.sv ====
`timescale 1ns/10ps

module vga_top (
   input  logic                   i_clock,
   input  logic                   i_reset,
   input  vga_cmd_pkg::vga_inst_t i_inst,
   input  logic                   i_inst_en,
   output logic                   o_error,
   output logic                   o_vga_hsync,
   output logic                   o_vga_vsync,
   output logic                   o_vga_r,
   output logic                   o_vga_g,
   output logic                   o_vga_b
);

   import vga_cmd_pkg::*;

   logic                      wr_en;
   logic [fb_addr_width-1:0]  wr_addr;
   logic [fb_color_width-1:0] wr_color;
   logic [fb_addr_width-1:0]  rd_addr;
   logic [fb_color_width-1:0] rd_color;

   vga_cmd_decoder u_decoder (
      .i_clock    (i_clock),
      .i_reset    (i_reset),
      .i_inst     (i_inst),
      .i_inst_en  (i_inst_en),
      .o_wr_en    (wr_en),
      .o_wr_addr  (wr_addr),
      .o_wr_color (wr_color),
      .o_error    (o_error)
   );

   frame_buffer u_frame_buffer (
      .i_clock    (i_clock),
      .i_wr_en    (wr_en),
      .i_wr_addr  (wr_addr),
      .i_wr_color (wr_color),
      .i_rd_addr  (rd_addr),
      .o_rd_color (rd_color)
   );

   // scan side, reads the buffer once per screen pixel
   vga_timing_gen u_timing_gen (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .o_rd_addr   (rd_addr),
      .i_rd_color  (rd_color),
      .o_vga_hsync (o_vga_hsync),
      .o_vga_vsync (o_vga_vsync),
      .o_vga_r     (o_vga_r),
      .o_vga_g     (o_vga_g),
      .o_vga_b     (o_vga_b)
   );

endmodule

// ==== src.f ====
logic/vga_cmd_pkg.sv
logic/vga_timing_pkg.sv
logic/vga_cmd_decoder.sv
logic/frame_buffer.sv
logic/vga_timing_gen.sv
logic/vga_top.sv
dv/vga_assert.sv
dv/vga_tb.sv
